//--- Makefile
TOP := tb_dual_lane_receiver

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- hdl/byte_deserializer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte deserializer for one lane.
// hunts for a run of sync bytes, then strobes out every data byte.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module byte_deserializer #(
  parameter int SYNC_COUNT = 4
) (
  input  wire                 clk8f,
  input  wire                 reset,
  input  wire                 serial,
  output lane_pkg::byte_t     data,
  output logic                valid,
  output logic                active
);

  localparam int CNT_W = $clog2(SYNC_COUNT + 1);

  lane_pkg::byte_t       shift_reg;
  lane_pkg::bit_cnt_t    bit_cnt;
  logic                  byte_done;
  logic [CNT_W-1:0]      sync_cnt;
  lane_pkg::sync_state_e state;
  logic                  is_sync;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bit shifter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // msb arrives first, so new bits enter at the bottom.
  always_ff @(posedge clk8f) begin
    shift_reg <= {shift_reg[6:0], serial};
  end

  // byte_done marks the cycle in which shift_reg holds a whole byte.
  always_ff @(posedge clk8f) begin
    if (reset) begin
      bit_cnt   <= '0;
      byte_done <= 1'b0;
    end else begin
      bit_cnt   <= bit_cnt + 1'b1;
      byte_done <= (bit_cnt == 3'd7);
    end
  end

  assign is_sync = (shift_reg == lane_pkg::SYNC_BYTE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sync state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk8f) begin
    if (reset) begin
      state    <= lane_pkg::SYNC_HUNT;
      sync_cnt <= '0;
    end else if (byte_done) begin
      case (state)
        lane_pkg::SYNC_HUNT: begin
          if (!is_sync) begin
            sync_cnt <= '0;
          end else if (sync_cnt == CNT_W'(SYNC_COUNT - 1)) begin
            state <= lane_pkg::SYNC_ACTIVE;
          end else begin
            sync_cnt <= sync_cnt + 1'b1;
          end
        end
        default: begin
          // once active, the lane holds until reset.
          state <= lane_pkg::SYNC_ACTIVE;
        end
      endcase
    end
  end

  assign active = (state == lane_pkg::SYNC_ACTIVE);

  // sync bytes seen while active are idle fill and are dropped.
  always_ff @(posedge clk8f) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= byte_done && active && !is_sync;
    end
  end

  always_ff @(posedge clk8f) begin
    if (byte_done) begin
      data <= shift_reg;
    end
  end

endmodule

`default_nettype wire

//--- hdl/byte_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// synchronous byte FIFO with empty, almost-full and sticky overflow.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire             clk8f,
  input  wire             reset,
  input  wire             push,
  input  lane_pkg::byte_t push_data,
  input  wire             pop,
  output lane_pkg::byte_t data_out,
  output logic            empty,
  output logic            almost_full,
  output logic            overflow
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  lane_pkg::byte_t  mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage and pointers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk8f) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // depth is a power of two, so the pointers wrap on their own.
  always_ff @(posedge clk8f) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // a push against a full FIFO is lost, so flag it until reset.
  always_ff @(posedge clk8f) begin
    if (reset) begin
      overflow <= 1'b0;
    end else if (push && full) begin
      overflow <= 1'b1;
    end
  end

  assign data_out    = mem[rd_ptr];
  assign empty       = (count == '0);
  assign almost_full = (count >= CNT_W'(FIFO_DEPTH - 1));

endmodule

`default_nettype wire

//--- hdl/dual_lane_receiver.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-lane serial receiver top level.
// each lane deserializes into its own FIFO, the merge block pairs them.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dual_lane_receiver #(
  parameter int FIFO_DEPTH = 4,
  parameter int SYNC_COUNT = 4
) (
  input  wire             clk8f,
  input  wire             reset,
  input  wire             in1,
  input  wire             in2,
  input  wire             read,
  output lane_pkg::byte_t out1,
  output lane_pkg::byte_t out2,
  output logic            out_valid,
  output logic            almost_full1,
  output logic            almost_full2,
  output logic            overflow1,
  output logic            overflow2,
  output logic            active1,
  output logic            active2
);

  lane_pkg::byte_t deser_data1;
  lane_pkg::byte_t deser_data2;
  logic            deser_valid1;
  logic            deser_valid2;
  lane_pkg::byte_t head1;
  lane_pkg::byte_t head2;
  logic            empty1;
  logic            empty2;
  logic            fifo_af1;
  logic            fifo_af2;
  logic            pop;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lane 1
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  byte_deserializer #(.SYNC_COUNT(SYNC_COUNT)) lane1_deser (
    .clk8f  (clk8f),
    .reset  (reset),
    .serial (in1),
    .data   (deser_data1),
    .valid  (deser_valid1),
    .active (active1)
  );

  byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) lane1_fifo (
    .clk8f       (clk8f),
    .reset       (reset),
    .push        (deser_valid1),
    .push_data   (deser_data1),
    .pop         (pop),
    .data_out    (head1),
    .empty       (empty1),
    .almost_full (fifo_af1),
    .overflow    (overflow1)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lane 2
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  byte_deserializer #(.SYNC_COUNT(SYNC_COUNT)) lane2_deser (
    .clk8f  (clk8f),
    .reset  (reset),
    .serial (in2),
    .data   (deser_data2),
    .valid  (deser_valid2),
    .active (active2)
  );

  byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) lane2_fifo (
    .clk8f       (clk8f),
    .reset       (reset),
    .push        (deser_valid2),
    .push_data   (deser_data2),
    .pop         (pop),
    .data_out    (head2),
    .empty       (empty2),
    .almost_full (fifo_af2),
    .overflow    (overflow2)
  );

  lane_merge merge0 (
    .clk8f     (clk8f),
    .reset     (reset),
    .read      (read),
    .empty1    (empty1),
    .empty2    (empty2),
    .data1     (head1),
    .data2     (head2),
    .pop       (pop),
    .out1      (out1),
    .out2      (out2),
    .out_valid (out_valid)
  );

  // almost-full leaves the chip one cycle behind the FIFO flags.
  always_ff @(posedge clk8f) begin
    if (reset) begin
      almost_full1 <= 1'b0;
      almost_full2 <= 1'b0;
    end else begin
      almost_full1 <= fifo_af1;
      almost_full2 <= fifo_af2;
    end
  end

endmodule

`default_nettype wire

//--- hdl/lane_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pops both lane FIFOs together and registers the byte pair.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lane_merge (
  input  wire             clk8f,
  input  wire             reset,
  input  wire             read,
  input  wire             empty1,
  input  wire             empty2,
  input  lane_pkg::byte_t data1,
  input  lane_pkg::byte_t data2,
  output logic            pop,
  output lane_pkg::byte_t out1,
  output lane_pkg::byte_t out2,
  output logic            out_valid
);

  // both lanes must hold a byte, so neither FIFO can underflow
  // and the lanes stay in lockstep.
  assign pop = read && !empty1 && !empty2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output pair register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk8f) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop;
    end
  end

  // the head bytes are captured in the same cycle as the pop.
  always_ff @(posedge clk8f) begin
    if (pop) begin
      out1 <= data1;
      out2 <= data2;
    end
  end

endmodule

`default_nettype wire

//--- hdl/lane_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants for the two-lane serial receiver.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lane_pkg;

  // one received data byte.
  typedef logic [7:0] byte_t;

  // bit position inside the byte being assembled.
  typedef logic [2:0] bit_cnt_t;

  // lane synchronisation states.
  typedef enum logic {
    SYNC_HUNT   = 1'b0,
    SYNC_ACTIVE = 1'b1
  } sync_state_e;

  // sync and idle fill byte.
  localparam byte_t SYNC_BYTE = 8'hBC;

endpackage

`default_nettype wire

//--- verif/dual_lane_receiver_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port assertions for the two-lane receiver.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dual_lane_receiver_assert (
  input wire clk8f,
  input wire reset,
  input wire read,
  input wire out_valid,
  input wire overflow1,
  input wire overflow2
);

  // reset is synchronous, so out_valid is clear from the edge after it.
  reset_clears_valid: assert property (@(posedge clk8f) reset |=> !out_valid)
    else $error("out_valid high after a reset cycle");

  overflow1_sticky: assert property (@(posedge clk8f) (overflow1 && !reset) |=> overflow1)
    else $error("overflow1 fell without reset");

  overflow2_sticky: assert property (@(posedge clk8f) (overflow2 && !reset) |=> overflow2)
    else $error("overflow2 fell without reset");

  // every pair comes from a pop made while read was high.
  valid_needs_read: assert property (
    @(posedge clk8f) disable iff (reset) out_valid |-> $past(read)
  ) else $error("out_valid high without read in the cycle before");

endmodule

bind dual_lane_receiver dual_lane_receiver_assert assert0 (
  .clk8f     (clk8f),
  .reset     (reset),
  .read      (read),
  .out_valid (out_valid),
  .overflow1 (overflow1),
  .overflow2 (overflow2)
);

`default_nettype wire

//--- verif/tb_dual_lane_receiver.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the two-lane receiver.
// seeded random lane streams checked against a queue model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_dual_lane_receiver;

  localparam int FIFO_DEPTH = 4;
  localparam int SYNC_COUNT = 4;
  // upper bound on bytes sent over all tests, reset time counted as bytes.
  localparam int STIM_BYTES = 160;
  localparam int CYCLE_LIMIT = STIM_BYTES * 8 * 2 + 200;
  localparam lane_pkg::byte_t IDLE = lane_pkg::SYNC_BYTE;

  logic            clk8f;
  logic            reset;
  logic            in1;
  logic            in2;
  logic            read;
  lane_pkg::byte_t out1;
  lane_pkg::byte_t out2;
  logic            out_valid;
  logic            almost_full1;
  logic            almost_full2;
  logic            overflow1;
  logic            overflow2;
  logic            active1;
  logic            active2;

  integer          seed = 32'hae66;
  int              errors = 0;
  int              err_mark;
  int              tests_run = 0;
  int              tests_failed = 0;
  int              pair_count;
  int              pushed1;
  int              pushed2;
  int              cycle_count = 0;
  int              sync_run1;
  int              sync_run2;
  lane_pkg::byte_t exp_q1[$];
  lane_pkg::byte_t exp_q2[$];

  dual_lane_receiver #(.FIFO_DEPTH(FIFO_DEPTH), .SYNC_COUNT(SYNC_COUNT)) dut0 (.*);

  initial begin
    clk8f = 1'b0;
    forever #50 clk8f = ~clk8f;
  end

  always @(posedge clk8f) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic void check_value(input string name, input int got, input int expv);
    assert (got == expv) else begin
      $display("ERROR %s got %h expected %h", name, got, expv);
      errors++;
    end
  endfunction

  function automatic lane_pkg::byte_t rand_data();
    lane_pkg::byte_t b;
    b = IDLE;
    while (b == IDLE) begin
      b = 8'($random(seed));
    end
    return b;
  endfunction

  // a lane goes active after SYNC_COUNT sync bytes in a row.
  // with read low nothing drains, so bytes past the depth are lost.
  function automatic void model_lane(input lane_pkg::byte_t b, ref int run,
                                     ref lane_pkg::byte_t q[$], ref int pushed);
    if (run < SYNC_COUNT) begin
      run = (b == IDLE) ? run + 1 : 0;
    end else if (b != IDLE && (read || q.size() < FIFO_DEPTH)) begin
      q.push_back(b);
      pushed++;
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_pair(input lane_pkg::byte_t b1, input lane_pkg::byte_t b2);
    for (int i = 7; i >= 0; i--) begin
      in1 = b1[i];
      in2 = b2[i];
      @(posedge clk8f);
      #10;
    end
    model_lane(b1, sync_run1, exp_q1, pushed1);
    model_lane(b2, sync_run2, exp_q2, pushed2);
  endtask

  // the byte grid restarts at reset release, so the next bit goes out in this slot.
  task automatic do_reset();
    reset = 1'b1;
    in1 = 1'b0;
    in2 = 1'b0;
    @(posedge clk8f);
    #10;
    check_value("out_valid", out_valid, 0);
    repeat (15) @(posedge clk8f);
    #10;
    check_value("{active1,active2}", {active1, active2}, 0);
    check_value("{overflow1,overflow2}", {overflow1, overflow2}, 0);
    reset = 1'b0;
    sync_run1 = 0;
    sync_run2 = 0;
    exp_q1.delete();
    exp_q2.delete();
  endtask

  task automatic start_synced();
    do_reset();
    repeat (SYNC_COUNT) send_pair(IDLE, IDLE);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q1.size() > 0 && exp_q2.size() > 0 && n < 8) begin
      send_pair(IDLE, IDLE);
      n++;
    end
    assert (exp_q1.size() == 0 || exp_q2.size() == 0) else begin
      $display("pairs stopped coming out while both lanes still held data");
      errors++;
    end
  endtask

  task automatic begin_test();
    err_mark = errors;
    pair_count = 0;
    pushed1 = 0;
    pushed2 = 0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, errors - err_mark);
    end
  endtask

  // every pair is compared with the heads of the two model queues.
  always @(negedge clk8f) begin
    if (!reset && out_valid) begin
      assert (exp_q1.size() > 0 && exp_q2.size() > 0) else begin
        $display("a pair came out while a lane had no byte expected");
        errors++;
      end
      if (exp_q1.size() > 0 && exp_q2.size() > 0) begin
        check_value("out1", out1, exp_q1.pop_front());
        check_value("out2", out2, exp_q2.pop_front());
        pair_count++;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    lane_pkg::byte_t b1;
    lane_pkg::byte_t b2;
    reset = 1'b1;
    in1 = 1'b0;
    in2 = 1'b0;
    read = 1'b0;
    @(posedge clk8f);
    #10;

    begin_test();
    do_reset();
    read = 1'b1;
    repeat (3) send_pair(rand_data(), rand_data());
    repeat (SYNC_COUNT - 1) send_pair(IDLE, IDLE);
    repeat (3) send_pair(rand_data(), rand_data());
    check_value("{active1,active2}", {active1, active2}, 0);
    repeat (SYNC_COUNT + 1) send_pair(IDLE, IDLE);
    check_value("{active1,active2}", {active1, active2}, 3);
    check_value("pair count", pair_count, 0);
    end_test("before sync");

    begin_test();
    start_synced();
    for (int i = 0; i < 24; i++) begin
      if (($random(seed) & 3) == 0) begin
        send_pair(IDLE, IDLE);
      end else begin
        send_pair(rand_data(), rand_data());
      end
    end
    drain();
    check_value("pair count", pair_count, pushed1);
    check_value("lane bytes left", exp_q1.size() + exp_q2.size(), 0);
    end_test("in-order pairing");

    // lane 2 carries one data byte per three slots.
    begin_test();
    start_synced();
    for (int i = 0; i < 9; i++) begin
      b1 = (i < 3) ? rand_data() : IDLE;
      b2 = (i % 3 == 0 && i < 6) ? rand_data() : IDLE;
      send_pair(b1, b2);
    end
    drain();
    check_value("pair count", pair_count, (pushed1 < pushed2) ? pushed1 : pushed2);
    end_test("unequal rates");

    begin_test();
    start_synced();
    read = 1'b0;
    repeat (FIFO_DEPTH - 1) send_pair(rand_data(), rand_data());
    send_pair(IDLE, IDLE);
    check_value("{almost_full1,almost_full2}", {almost_full1, almost_full2}, 3);
    check_value("{overflow1,overflow2}", {overflow1, overflow2}, 0);
    read = 1'b1;
    drain();
    check_value("pair count", pair_count, FIFO_DEPTH - 1);
    end_test("back-pressure");

    begin_test();
    start_synced();
    read = 1'b0;
    repeat (FIFO_DEPTH + 2) send_pair(rand_data(), rand_data());
    send_pair(IDLE, IDLE);
    check_value("{overflow1,overflow2}", {overflow1, overflow2}, 3);
    read = 1'b1;
    drain();
    check_value("pair count", pair_count, FIFO_DEPTH);
    check_value("{overflow1,overflow2}", {overflow1, overflow2}, 3);
    end_test("overflow");

    // the reset lands while a pair is on the outputs.
    begin_test();
    start_synced();
    read = 1'b0;
    repeat (FIFO_DEPTH + 1) send_pair(rand_data(), rand_data());
    send_pair(IDLE, IDLE);
    check_value("{overflow1,overflow2}", {overflow1, overflow2}, 3);
    read = 1'b1;
    @(posedge clk8f);
    #10;
    check_value("out_valid", out_valid, 1);
    do_reset();
    repeat (3) send_pair(rand_data(), rand_data());
    check_value("{active1,active2}", {active1, active2}, 0);
    check_value("pair count", pair_count, 0);
    repeat (SYNC_COUNT) send_pair(IDLE, IDLE);
    repeat (4) send_pair(rand_data(), rand_data());
    drain();
    check_value("pair count", pair_count, 4);
    end_test("reset recovery");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
hdl/lane_pkg.sv
hdl/byte_deserializer.sv
hdl/byte_fifo.sv
hdl/lane_merge.sv
hdl/dual_lane_receiver.sv
verif/dual_lane_receiver_assert.sv
verif/tb_dual_lane_receiver.sv
